//--- hdl/egr_defs.svh
/*
 * widths, depths and counts shared by the egress block
 */

`ifndef EGR_DEFS_SVH
`define EGR_DEFS_SVH

// --------------------------------------------------
// ports and tags
// --------------------------------------------------
`define EGR_NUM_PORTS     4
`define EGR_PORT_W        2
`define EGR_PTR_W         6
// byte length of one segment, 1 to 32
`define EGR_LEN_W         6
`define EGR_WCNT_W        3
`define EGR_QUEUE_DEPTH   4

// --------------------------------------------------
// data side
// --------------------------------------------------
`define EGR_WORDS_PER_SEG 4
`define EGR_WIDX_W        2
`define EGR_ADDR_W        8
`define EGR_DATA_W        64
`define EGR_BYTES_W       4
`define EGR_TX_CREDITS    4

`endif

//--- hdl/egr_tag_pkg.sv
/*
 * tag-side types: ring tag and per-port queue entry
 */

`include "egr_defs.svh"

package egr_tag_pkg;

  // --------------------------------------------------
  // scalar fields
  // --------------------------------------------------
  typedef logic [`EGR_PORT_W-1:0] egr_port_t;
  typedef logic [`EGR_PTR_W-1:0]  egr_ptr_t;
  // segment length in bytes
  typedef logic [`EGR_LEN_W-1:0]  egr_len_t;
  // words in a segment, 1 to EGR_WORDS_PER_SEG
  typedef logic [`EGR_WCNT_W-1:0] egr_wcnt_t;

  // tag as it arrives from the ring
  typedef struct packed {
    logic      valid;
    logic      eop;
    egr_port_t port;
    egr_ptr_t  ptr;
    egr_len_t  length;
  } egr_tag_t;

  // one queued segment, already decoded into words
  typedef struct packed {
    egr_ptr_t                ptr;
    logic                    eop;
    egr_wcnt_t               wcnt;
    // valid bytes in the last word, 1 to 8
    logic [`EGR_BYTES_W-1:0] last_bytes;
  } egr_qentry_t;

endpackage

//--- hdl/egr_data_pkg.sv
/*
 * data-side types: memory word, write port, transmit word
 */

`include "egr_defs.svh"

package egr_data_pkg;

  typedef logic [`EGR_DATA_W-1:0] egr_data_t;
  // word address, segment pointer on top and word index below
  typedef logic [`EGR_ADDR_W-1:0] egr_addr_t;

  // environment write into segment memory
  typedef struct packed {
    logic      valid;
    egr_addr_t addr;
    egr_data_t data;
  } egr_mem_wr_t;

  // --------------------------------------------------
  // word toward one EPL
  // --------------------------------------------------
  typedef struct packed {
    logic                    valid;
    logic                    sop;
    logic                    eop;
    // valid bytes in this word, 1 to 8
    logic [`EGR_BYTES_W-1:0] bytes;
    egr_data_t               data;
  } egr_tx_word_t;

endpackage

//--- hdl/egr_tag_dispatch.sv
/*
 * tag dispatch: registers ring tags, decodes word counts,
 * pushes each tag into its port queue
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_tag_dispatch (
  input  logic                      clk,
  input  logic                      rst,
  input  egr_tag_pkg::egr_tag_t     tag_in,
  output logic [`EGR_NUM_PORTS-1:0] push,
  output egr_tag_pkg::egr_qentry_t  entry
);

  // registered ring tag
  egr_tag_pkg::egr_tag_t tag_q;

  // length plus 7 in one extra bit
  logic [`EGR_LEN_W:0] len_round;

  // --------------------------------------------------
  // input register
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    tag_q <= tag_in;
    // reset clears the tag valid bit
    if (rst) begin
      tag_q.valid <= 1'b0;
    end
  end

  // --------------------------------------------------
  // port decode
  // --------------------------------------------------
  // one-hot push one cycle after tag_in.valid
  always_comb begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      push[p] = tag_q.valid && (tag_q.port == egr_tag_pkg::egr_port_t'(p));
    end
  end

  // --------------------------------------------------
  // length decode
  // --------------------------------------------------
  // word count is length / 8 rounded up
  assign len_round = {1'b0, tag_q.length} + (`EGR_LEN_W+1)'(7);

  always_comb begin
    entry.ptr  = tag_q.ptr;
    entry.eop  = tag_q.eop;
    entry.wcnt = len_round[`EGR_WCNT_W+2:3];
    // last-word bytes are the remainder of length / 8
    // a zero remainder means a full word
    if (tag_q.length[2:0] == 3'd0) begin
      entry.last_bytes = `EGR_BYTES_W'(8);
    end else begin
      entry.last_bytes = `EGR_BYTES_W'(tag_q.length[2:0]);
    end
  end

endmodule

//--- hdl/egr_port_queue.sv
/*
 * tag FIFO for one transmit port
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_port_queue (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     push,
  input  egr_tag_pkg::egr_qentry_t entry_in,
  input  logic                     pop,
  output egr_tag_pkg::egr_qentry_t head,
  output logic                     not_empty
);

  localparam int PTR_W = $clog2(`EGR_QUEUE_DEPTH);
  localparam int CNT_W = $clog2(`EGR_QUEUE_DEPTH + 1);

  egr_tag_pkg::egr_qentry_t mem [`EGR_QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------
  // write at the tail on each push
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= entry_in;
    end
  end

  // --------------------------------------------------
  // pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the count alone
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // head shows up the cycle after its push
  assign head      = mem[rd_ptr];
  assign not_empty = (count != '0);

endmodule

//--- hdl/egr_seg_mem.sv
/*
 * segment word memory, one write port and one registered read
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_seg_mem (
  input  logic                     clk,
  input  egr_data_pkg::egr_mem_wr_t wr,
  input  egr_data_pkg::egr_addr_t   rd_addr,
  output egr_data_pkg::egr_data_t   rd_data
);

  localparam int NUM_WORDS = 1 << `EGR_ADDR_W;

  // segments are never freed, so the contents only change on writes
  egr_data_pkg::egr_data_t mem [NUM_WORDS];

  // --------------------------------------------------
  // write port
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (wr.valid) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // --------------------------------------------------
  // read port
  // --------------------------------------------------
  // data one cycle after the address
  // a same-cycle write to the read address returns the old word
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- hdl/egr_tx_sched.sv
/*
 * round-robin segment scheduler: word credits, memory reads,
 * transmit words toward the four EPLs
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_tx_sched (
  input  logic                      clk,
  input  logic                      rst,
  input  egr_tag_pkg::egr_qentry_t  head [`EGR_NUM_PORTS],
  input  logic [`EGR_NUM_PORTS-1:0] not_empty,
  input  logic [`EGR_NUM_PORTS-1:0] tx_credit,
  output logic [`EGR_NUM_PORTS-1:0] pop,
  output egr_data_pkg::egr_addr_t   rd_addr,
  input  egr_data_pkg::egr_data_t   rd_data,
  output egr_data_pkg::egr_tx_word_t tx [`EGR_NUM_PORTS]
);

  localparam int CRED_W = $clog2(`EGR_TX_CREDITS + 1);

  typedef enum logic {
    IDLE,
    SEND
  } state_t;

  state_t                    state;
  egr_tag_pkg::egr_port_t    sel_port;
  logic [`EGR_WIDX_W-1:0]    word_idx;
  egr_tag_pkg::egr_qentry_t  cur;

  // round-robin pick
  logic                      pick_valid;
  egr_tag_pkg::egr_port_t    pick_port;

  // issue of one word this cycle
  logic                      issue;
  logic                      last_word;
  logic [`EGR_NUM_PORTS-1:0] spend;
  logic [CRED_W-1:0]         credit [`EGR_NUM_PORTS];

  // word info travelling alongside the memory read
  logic                      iss_valid;
  egr_tag_pkg::egr_port_t    iss_port;
  logic                      iss_sop;
  logic                      iss_eop;
  logic [`EGR_BYTES_W-1:0]   iss_bytes;

  // --------------------------------------------------
  // round robin
  // --------------------------------------------------
  // search starts one past the port served last
  always_comb begin : rr_pick
    egr_tag_pkg::egr_port_t cand;
    pick_valid = 1'b0;
    pick_port  = sel_port;
    for (int i = 1; i <= `EGR_NUM_PORTS; i++) begin
      cand = sel_port + egr_tag_pkg::egr_port_t'(i);
      if (!pick_valid && not_empty[cand]) begin
        pick_valid = 1'b1;
        pick_port  = cand;
      end
    end
  end

  // --------------------------------------------------
  // word issue
  // --------------------------------------------------
  assign cur       = head[sel_port];
  // no credit on the selected port stalls everything
  assign issue     = (state == SEND) && (credit[sel_port] != '0);
  assign last_word = (`EGR_WCNT_W'(word_idx) + 1'b1) == cur.wcnt;
  assign rd_addr   = {cur.ptr, word_idx};

  // pop on the last word, which also returns the tag credit
  always_comb begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      spend[p] = issue && (sel_port == egr_tag_pkg::egr_port_t'(p));
      pop[p]   = spend[p] && last_word;
    end
  end

  // FSM, one segment per pass through SEND
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      sel_port <= egr_tag_pkg::egr_port_t'(`EGR_NUM_PORTS - 1);
      word_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (pick_valid) begin
            state    <= SEND;
            sel_port <= pick_port;
            word_idx <= '0;
          end
        end
        SEND: begin
          if (issue) begin
            word_idx <= word_idx + 1'b1;
            if (last_word) begin
              state <= IDLE;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // --------------------------------------------------
  // word credits
  // --------------------------------------------------
  // return and spend in one cycle cancel out
  always_ff @(posedge clk) begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      if (rst) begin
        credit[p] <= CRED_W'(`EGR_TX_CREDITS);
      end else begin
        credit[p] <= credit[p] + CRED_W'(tx_credit[p]) - CRED_W'(spend[p]);
      end
    end
  end

  // --------------------------------------------------
  // read pipeline
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= issue;
    end
  end

  always_ff @(posedge clk) begin
    iss_port  <= sel_port;
    iss_sop   <= (word_idx == '0);
    // eop marks the end of the packet, not of every segment
    iss_eop   <= last_word && cur.eop;
    iss_bytes <= last_word ? cur.last_bytes : `EGR_BYTES_W'(8);
  end

  // data lines are shared, valid steers the word to one EPL
  always_comb begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      tx[p].valid = iss_valid && (iss_port == egr_tag_pkg::egr_port_t'(p));
      tx[p].sop   = iss_sop;
      tx[p].eop   = iss_eop;
      tx[p].bytes = iss_bytes;
      tx[p].data  = rd_data;
    end
  end

endmodule

//--- hdl/egr_top.sv
/*
 * egress top: tag dispatch, four port queues, segment memory
 * and transmit scheduler
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_top (
  input  logic                       clk,
  input  logic                       rst,
  // tag ring
  input  egr_tag_pkg::egr_tag_t      tag_in,
  output logic [`EGR_NUM_PORTS-1:0]  tag_credit,
  // segment memory fill
  input  egr_data_pkg::egr_mem_wr_t  mem_wr,
  // EPL side
  output egr_data_pkg::egr_tx_word_t tx [`EGR_NUM_PORTS],
  input  logic [`EGR_NUM_PORTS-1:0]  tx_credit
);

  // dispatch to queues
  logic [`EGR_NUM_PORTS-1:0] push;
  egr_tag_pkg::egr_qentry_t  entry;

  // queues to scheduler
  egr_tag_pkg::egr_qentry_t  head [`EGR_NUM_PORTS];
  logic [`EGR_NUM_PORTS-1:0] not_empty;
  logic [`EGR_NUM_PORTS-1:0] pop;

  // scheduler to memory
  egr_data_pkg::egr_addr_t   rd_addr;
  egr_data_pkg::egr_data_t   rd_data;

  // --------------------------------------------------
  // tag path
  // --------------------------------------------------
  egr_tag_dispatch u_dispatch (
    .clk    (clk),
    .rst    (rst),
    .tag_in (tag_in),
    .push   (push),
    .entry  (entry)
  );

  for (genvar p = 0; p < `EGR_NUM_PORTS; p++) begin : g_queue
    egr_port_queue u_queue (
      .clk       (clk),
      .rst       (rst),
      .push      (push[p]),
      .entry_in  (entry),
      .pop       (pop[p]),
      .head      (head[p]),
      .not_empty (not_empty[p])
    );
  end

  // each pop frees one tag slot on the ring
  assign tag_credit = pop;

  // --------------------------------------------------
  // data path
  // --------------------------------------------------
  egr_seg_mem u_seg_mem (
    .clk     (clk),
    .wr      (mem_wr),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  egr_tx_sched u_sched (
    .clk       (clk),
    .rst       (rst),
    .head      (head),
    .not_empty (not_empty),
    .tx_credit (tx_credit),
    .pop       (pop),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .tx        (tx)
  );

endmodule

//--- tests/egr_top_tb_app.sv
/*
 * egress stimulus: LCG, segment memory fill, ring tags under
 * tag slots, word credit return with random delays
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_top_tb_app #(
  parameter int NUM_TAGS = 201,
  parameter int HOLD_CYC = 200
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`EGR_NUM_PORTS-1:0] tag_credit,
  input  logic [`EGR_NUM_PORTS-1:0] tx_valid,
  output egr_tag_pkg::egr_tag_t     tag_in,
  output egr_data_pkg::egr_mem_wr_t mem_wr,
  output logic [`EGR_NUM_PORTS-1:0] tx_credit,
  output logic                      hold_p1,
  output logic [1:0]                phase,
  output logic                      done
);

  localparam logic [31:0] SEED = 32'h78cf_a53d;

  logic [31:0] tag_rng;
  logic [31:0] cred_rng;
  // tag slots the ring still holds per port
  int          slots [`EGR_NUM_PORTS];

  function automatic logic [31:0] lcg_next(inout logic [31:0] state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // advance one clock and collect returned tag slots before inputs change 1 ns later
  task automatic step_cycle();
    @(posedge clk);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      if (tag_credit[p] === 1'b1) begin
        slots[p]++;
      end
    end
    #1;
  endtask

  // --------------------------------------------------
  // memory fill
  // --------------------------------------------------
  task automatic fill_memory();
    logic [31:0] hi;
    logic [31:0] lo;
    for (int a = 0; a < (1 << `EGR_ADDR_W); a++) begin
      hi = lcg_next(tag_rng);
      lo = lcg_next(tag_rng);
      mem_wr.valid = 1'b1;
      mem_wr.addr  = egr_data_pkg::egr_addr_t'(a);
      mem_wr.data  = {hi, lo};
      @(posedge clk);
      #1;
    end
    mem_wr = '0;
  endtask

  // --------------------------------------------------
  // tags
  // --------------------------------------------------
  task automatic send_single();
    // full 32-byte eop segment to port 2
    tag_in = '{valid: 1'b1, eop: 1'b1, port: 2'd2, ptr: 6'h15, length: 6'd32};
    slots[2]--;
    step_cycle();
    tag_in.valid = 1'b0;
    while (slots[2] != `EGR_QUEUE_DEPTH) step_cycle();
    // the last word leaves one cycle after its tag credit
    step_cycle();
  endtask

  task automatic send_random();
    logic [31:0]            r;
    egr_tag_pkg::egr_port_t port;
    int                     sent;
    int                     cyc;
    sent = 1;
    cyc  = 0;
    // port 1 gets no word credit back for the first HOLD_CYC cycles
    while (sent < NUM_TAGS || cyc < HOLD_CYC) begin
      r       = lcg_next(tag_rng);
      port    = r[31:30];
      hold_p1 = (cyc < HOLD_CYC);
      if (sent < NUM_TAGS && r[29:27] != 3'd0 && slots[port] > 0) begin
        tag_in.valid  = 1'b1;
        tag_in.eop    = r[26];
        tag_in.port   = port;
        tag_in.ptr    = r[25:20];
        tag_in.length = egr_tag_pkg::egr_len_t'(r[19:15]) + 1'b1;
        slots[port]--;
        sent++;
      end else begin
        tag_in.valid = 1'b0;
      end
      step_cycle();
      cyc++;
    end
    tag_in.valid = 1'b0;
    hold_p1      = 1'b0;
  endtask

  // --------------------------------------------------
  // word credit return
  // --------------------------------------------------
  task automatic return_credits();
    int                        pending [`EGR_NUM_PORTS];
    int                        delay   [`EGR_NUM_PORTS];
    logic [`EGR_NUM_PORTS-1:0] pulse;
    logic [31:0]               r;
    logic                      hold;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      pending[p] = 0;
      delay[p]   = 0;
    end
    forever begin
      @(posedge clk);
      hold = hold_p1;
      for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
        pulse[p] = 1'b0;
        if (tx_valid[p] === 1'b1) begin
          pending[p]++;
        end
        if (pending[p] > 0 && !(p == 1 && hold)) begin
          if (delay[p] == 0) begin
            pulse[p] = 1'b1;
            pending[p]--;
            r        = lcg_next(cred_rng);
            delay[p] = int'(r[31:29]);
          end else begin
            delay[p]--;
          end
        end
      end
      #1;
      tx_credit = pulse;
    end
  endtask

  initial begin : stimulus
    tag_in    = '0;
    mem_wr    = '0;
    tx_credit = '0;
    hold_p1   = 1'b0;
    phase     = 2'd0;
    done      = 1'b0;
    tag_rng   = SEED;
    cred_rng  = lcg_next(tag_rng);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      slots[p] = `EGR_QUEUE_DEPTH;
    end
    fork
      return_credits();
    join_none
    wait (rst === 1'b0);
    @(posedge clk);
    #1;
    fill_memory();
    phase = 2'd1;
    send_single();
    phase = 2'd2;
    send_random();
    done = 1'b1;
  end

endmodule

//--- tests/egr_top_tb.sv
/*
 * egress testbench: clock, reset, DUT, reference model of the
 * transmit words, compare tasks, timeout and final report
 */

`timescale 1ns/1ps
`include "egr_defs.svh"

module egr_top_tb;

  // one directed tag followed by the random ones
  localparam int NUM_TAGS   = 201;
  localparam int HOLD_CYC   = 200;
  localparam int MAX_CYCLES = NUM_TAGS * `EGR_WORDS_PER_SEG * 10 + 2000;

  logic                       clk;
  logic                       rst;
  egr_tag_pkg::egr_tag_t      tag_in;
  logic [`EGR_NUM_PORTS-1:0]  tag_credit;
  egr_data_pkg::egr_mem_wr_t  mem_wr;
  egr_data_pkg::egr_tx_word_t tx [`EGR_NUM_PORTS];
  logic [`EGR_NUM_PORTS-1:0]  tx_credit;
  logic [`EGR_NUM_PORTS-1:0]  tx_valid;
  logic                       hold_p1;
  logic [1:0]                 phase;
  logic                       done;

  // reference model of the memory and the expected words per port
  egr_data_pkg::egr_data_t    model_mem [1 << `EGR_ADDR_W];
  egr_data_pkg::egr_tx_word_t exp_q [`EGR_NUM_PORTS][$];

  int value_errors;
  int other_errors;
  int cycle;
  bit seen_tag;
  int tags_sent    [`EGR_NUM_PORTS];
  int credits_seen [`EGR_NUM_PORTS];
  int words_rx     [`EGR_NUM_PORTS];
  int returned     [`EGR_NUM_PORTS];
  int p1_hold_words;
  int p1_after_words;

  // --------------------------------------------------
  // clock, reset, DUT and stimulus
  // --------------------------------------------------
  initial clk = 1'b0;
  always #10 clk = ~clk;

  initial begin
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
  end

  egr_top u_dut (
    .clk        (clk),
    .rst        (rst),
    .tag_in     (tag_in),
    .tag_credit (tag_credit),
    .mem_wr     (mem_wr),
    .tx         (tx),
    .tx_credit  (tx_credit)
  );

  egr_top_tb_app #(.NUM_TAGS(NUM_TAGS), .HOLD_CYC(HOLD_CYC)) u_app (
    .clk        (clk),
    .rst        (rst),
    .tag_credit (tag_credit),
    .tx_valid   (tx_valid),
    .tag_in     (tag_in),
    .mem_wr     (mem_wr),
    .tx_credit  (tx_credit),
    .hold_p1    (hold_p1),
    .phase      (phase),
    .done       (done)
  );

  always_comb begin
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      tx_valid[p] = tx[p].valid;
    end
  end

  // --------------------------------------------------
  // model and compare tasks
  // --------------------------------------------------
  function automatic string test_name();
    case (phase)
      2'd1:    return "single_tag";
      2'd2:    return "random_tags";
      default: return "idle";
    endcase
  endfunction

  // words of one segment from the tag fields and the memory mirror
  task automatic expect_segment(input egr_tag_pkg::egr_tag_t tag);
    int                         wcnt;
    int                         rem;
    egr_data_pkg::egr_tx_word_t w;
    wcnt = (int'(tag.length) + 7) / 8;
    rem  = int'(tag.length) % 8;
    for (int i = 0; i < wcnt; i++) begin
      w.valid = 1'b1;
      w.sop   = (i == 0);
      w.eop   = (i == wcnt - 1) && tag.eop;
      // a zero remainder is a full last word
      w.bytes = (i != wcnt - 1) ? 4'd8 : ((rem == 0) ? 4'd8 : 4'(rem));
      w.data  = model_mem[{tag.ptr, `EGR_WIDX_W'(i)}];
      exp_q[tag.port].push_back(w);
    end
  endtask

  task automatic check_tx(input string name, input egr_data_pkg::egr_tx_word_t exp,
                          input egr_data_pkg::egr_tx_word_t act);
    if (act !== exp) begin
      value_errors++;
      // fields shown as sop/eop/bytes/data
      $display("** Error %s: expected %0b/%0b/%0d/%h, actual %0b/%0b/%0d/%h", name,
               exp.sop, exp.eop, exp.bytes, exp.data, act.sop, act.eop, act.bytes, act.data);
    end
  endtask

  task automatic check_credit(input string name, input egr_tag_pkg::egr_port_t port,
                              input int exp, input int act);
    if (act != exp) begin
      value_errors++;
      $display("** Error %s port %0d: expected %0d, actual %0d", name, port, exp, act);
    end
  endtask

  function automatic bit drained();
    bit empty;
    empty = 1'b1;
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      if (exp_q[p].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic close_run(input bit timed_out);
    $display("errors: %0d value, %0d other, timeout %0d", value_errors, other_errors, timed_out);
    if (!timed_out && value_errors == 0 && other_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  // --------------------------------------------------
  // monitor sampled on the rising edge
  // --------------------------------------------------
  always @(posedge clk) begin : monitor
    egr_data_pkg::egr_tx_word_t exp_word;
    if (mem_wr.valid === 1'b1) begin
      model_mem[mem_wr.addr] = mem_wr.data;
    end
    if (tag_in.valid === 1'b1) begin
      // nothing may have come back before the first tag
      if (!seen_tag) begin
        for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
          check_credit("idle tag credit", egr_tag_pkg::egr_port_t'(p), 0, credits_seen[p]);
        end
      end
      seen_tag = 1'b1;
      tags_sent[tag_in.port]++;
      expect_segment(tag_in);
    end
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      if (!seen_tag && cycle > 0 && (tx[p].valid !== 1'b0 || tag_credit[p] !== 1'b0)) begin
        other_errors++;
        $display("port %0d output went active before the first tag", p);
      end
      if (tag_credit[p] === 1'b1) begin
        credits_seen[p]++;
      end
      if (tags_sent[p] - credits_seen[p] > `EGR_QUEUE_DEPTH) begin
        other_errors++;
        $display("port %0d holds more tags than it has slots", p);
      end
      if (tx[p].valid === 1'b1) begin
        words_rx[p]++;
        if (words_rx[p] > `EGR_TX_CREDITS + returned[p]) begin
          other_errors++;
          $display("port %0d sent a word without a word credit", p);
        end
        if (p == 1 && hold_p1) begin
          p1_hold_words++;
        end else if (p == 1 && phase == 2'd2) begin
          p1_after_words++;
        end
        if (exp_q[p].size() == 0) begin
          other_errors++;
          $display("port %0d sent a word that no tag asked for", p);
        end else begin
          exp_word = exp_q[p].pop_front();
          check_tx($sformatf("%s tx[%0d]", test_name(), p), exp_word, tx[p]);
        end
      end
      if (tx_credit[p] === 1'b1) begin
        returned[p]++;
      end
    end
    cycle++;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with traffic still pending", cycle);
      close_run(1'b1);
    end
  end

  // --------------------------------------------------
  // end of run
  // --------------------------------------------------
  initial begin : finish_check
    wait (done === 1'b1);
    // wait on falling edges until every expected word has arrived
    do @(negedge clk); while (!drained());
    repeat (10) @(negedge clk);
    for (int p = 0; p < `EGR_NUM_PORTS; p++) begin
      check_credit("tag credits", egr_tag_pkg::egr_port_t'(p), tags_sent[p], credits_seen[p]);
    end
    if (p1_hold_words > `EGR_TX_CREDITS) begin
      other_errors++;
      $display("port 1 kept sending while its word credits were held back");
    end
    if (p1_after_words == 0) begin
      other_errors++;
      $display("port 1 never resumed after its credit hold");
    end
    close_run(1'b0);
  end

endmodule

//--- egr_top.f
+incdir+hdl
hdl/egr_tag_pkg.sv
hdl/egr_data_pkg.sv
hdl/egr_tag_dispatch.sv
hdl/egr_port_queue.sv
hdl/egr_seg_mem.sv
hdl/egr_tx_sched.sv
hdl/egr_top.sv
tests/egr_top_tb_app.sv
tests/egr_top_tb.sv

//--- Bender.yml
package:
  name: egr_top

export_include_dirs:
  - hdl

sources:
  - hdl/egr_tag_pkg.sv
  - hdl/egr_data_pkg.sv
  - hdl/egr_tag_dispatch.sv
  - hdl/egr_port_queue.sv
  - hdl/egr_seg_mem.sv
  - hdl/egr_tx_sched.sv
  - hdl/egr_top.sv
  - target: test
    files:
      - tests/egr_top_tb_app.sv
      - tests/egr_top_tb.sv
